/* logic/rv_core_pkg.sv */
package rv_core_pkg;

	localparam int xlen = 32;
	localparam int num_regs = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam word_t reset_vector = '0;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,
		opc_jal    = 7'b1101111
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra
	} alu_op_e;

	// values match funct3 of the branch encoding
	typedef enum logic [2:0] {
		br_eq = 3'b000,
		br_ne = 3'b001,
		br_lt = 3'b100,
		br_ge = 3'b101
	} br_op_e;

	typedef enum logic {
		opb_rs2,
		opb_imm
	} opb_sel_e;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_pc4
	} wb_sel_e;

	typedef struct packed {
		logic reg_write;
		logic mem_access;
		logic mem_write;
		logic branch;
		logic jump;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t imm;
		alu_op_e alu_op;
		br_op_e br_op;
		opb_sel_e opb_sel;
		wb_sel_e wb_sel;
	} decoded_t;

	// internal request/acknowledge bus
	typedef struct packed {
		logic valid;
		logic write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic ack;
		word_t rdata;
	} mem_rsp_t;

	typedef enum logic {
		exec_run,
		exec_mem_wait
	} exec_state_e;

	typedef enum logic [1:0] {
		apb_idle,
		apb_setup,
		apb_access
	} apb_state_e;

endpackage

/* logic/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
	input logic clk,
	input logic rst_i,
	input logic redirect_i,
	input rv_core_pkg::word_t target_i,
	input logic instr_take_i,
	output rv_core_pkg::mem_req_t req_o,
	input rv_core_pkg::mem_rsp_t rsp_i,
	output logic instr_valid_o,
	output rv_core_pkg::word_t instr_o,
	output rv_core_pkg::word_t pc_o
);
	import rv_core_pkg::*;

	word_t pc_q;
	word_t req_addr_q;
	logic pending_q;
	logic discard_q;
	logic buf_valid_q;
	word_t buf_instr_q;
	word_t buf_pc_q;
	logic issue;
	logic accept;

	// new fetch once the buffer frees up, never on the old path of a redirect
	assign issue = !pending_q && (!buf_valid_q || instr_take_i) && !redirect_i;
	assign accept = rsp_i.ack && !discard_q && !redirect_i;

	always_comb begin
		req_o.valid = pending_q || issue;
		req_o.write = 1'b0;
		req_o.addr = pending_q ? req_addr_q : pc_q;
		req_o.wdata = '0;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_q <= reset_vector;
			pending_q <= 1'b0;
			discard_q <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			if (issue) begin
				pending_q <= 1'b1;
			end else if (rsp_i.ack) begin
				pending_q <= 1'b0;
			end
			if (redirect_i) begin
				pc_q <= target_i;
			end else if (accept) begin
				pc_q <= pc_q + 32'd4;
			end
			// response still in flight belongs to the abandoned path
			if (rsp_i.ack) begin
				discard_q <= 1'b0;
			end else if (redirect_i && pending_q) begin
				discard_q <= 1'b1;
			end
			if (redirect_i) begin
				buf_valid_q <= 1'b0;
			end else if (accept) begin
				buf_valid_q <= 1'b1;
			end else if (instr_take_i) begin
				buf_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			req_addr_q <= pc_q;
		end
		if (accept) begin
			buf_instr_q <= rsp_i.rdata;
			buf_pc_q <= req_addr_q;
		end
	end

	assign instr_valid_o = buf_valid_q;
	assign instr_o = buf_instr_q;
	assign pc_o = buf_pc_q;

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
	input logic clk,
	input logic rst_i,
	input logic instr_valid_i,
	input rv_core_pkg::word_t instr_i,
	input rv_core_pkg::word_t pc_i,
	output logic instr_take_o,
	output logic redirect_o,
	output rv_core_pkg::word_t target_o,
	output rv_core_pkg::mem_req_t req_o,
	input rv_core_pkg::mem_rsp_t rsp_i
);
	import rv_core_pkg::*;

	exec_state_e state_q;
	decoded_t dec;
	word_t rf [num_regs];
	word_t rs1_val;
	word_t rs2_val;
	word_t opb;
	word_t alu_res;
	word_t wb_data;
	logic br_taken;
	logic take;
	logic [2:0] funct3;
	logic f7_zero;
	logic f7_alt;
	logic rf_we;
	reg_addr_t rf_waddr;
	word_t rf_wdata;
	word_t addr_q;
	word_t wdata_q;
	logic write_q;
	reg_addr_t rd_q;

	function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? alu_sub : alu_add;
			3'b001: return alu_sll;
			3'b010: return alu_slt;
			3'b011: return alu_sltu;
			3'b100: return alu_xor;
			3'b101: return alt ? alu_sra : alu_srl;
			3'b110: return alu_or;
			default: return alu_and;
		endcase
	endfunction

	assign funct3 = instr_i[14:12];
	assign f7_zero = instr_i[31:25] == 7'b0000000;
	assign f7_alt = instr_i[31:25] == 7'b0100000;

	// unknown encodings leave every enable low and retire as no-ops
	always_comb begin
		dec = '0;
		dec.rd = instr_i[11:7];
		dec.rs1 = instr_i[19:15];
		dec.rs2 = instr_i[24:20];
		dec.imm = {{20{instr_i[31]}}, instr_i[31:20]};
		dec.alu_op = alu_add;
		dec.br_op = br_op_e'(funct3);
		dec.opb_sel = opb_imm;
		dec.wb_sel = wb_alu;
		case (instr_i[6:0])
			opc_op: begin
				dec.opb_sel = opb_rs2;
				dec.alu_op = alu_decode(funct3, f7_alt);
				dec.reg_write = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			opc_op_imm: begin
				dec.alu_op = alu_decode(funct3, f7_alt && funct3 == 3'b101);
				dec.reg_write = funct3[1:0] != 2'b01 || f7_zero || (f7_alt && funct3 == 3'b101);
			end
			opc_lui: begin
				dec.imm = {instr_i[31:12], 12'b0};
				dec.wb_sel = wb_imm;
				dec.reg_write = 1'b1;
			end
			opc_load: begin
				dec.mem_access = funct3 == 3'b010;
			end
			opc_store: begin
				dec.imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
				dec.mem_access = funct3 == 3'b010;
				dec.mem_write = funct3 == 3'b010;
			end
			opc_branch: begin
				dec.imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
				dec.branch = funct3[1] == 1'b0;
			end
			opc_jal: begin
				dec.imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
				dec.wb_sel = wb_pc4;
				dec.jump = 1'b1;
				dec.reg_write = 1'b1;
			end
			default: begin
				dec.reg_write = 1'b0;
			end
		endcase
	end

	assign rs1_val = rf[dec.rs1];
	assign rs2_val = rf[dec.rs2];
	assign opb = (dec.opb_sel == opb_rs2) ? rs2_val : dec.imm;

	always_comb begin
		case (dec.alu_op)
			alu_sub: alu_res = rs1_val - opb;
			alu_and: alu_res = rs1_val & opb;
			alu_or: alu_res = rs1_val | opb;
			alu_xor: alu_res = rs1_val ^ opb;
			alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(rs1_val) < $signed(opb)};
			alu_sltu: alu_res = {{(xlen-1){1'b0}}, rs1_val < opb};
			alu_sll: alu_res = rs1_val << opb[4:0];
			alu_srl: alu_res = rs1_val >> opb[4:0];
			alu_sra: alu_res = $signed(rs1_val) >>> opb[4:0];
			default: alu_res = rs1_val + opb;
		endcase
		case (dec.br_op)
			br_eq: br_taken = rs1_val == rs2_val;
			br_ne: br_taken = rs1_val != rs2_val;
			br_lt: br_taken = $signed(rs1_val) < $signed(rs2_val);
			br_ge: br_taken = $signed(rs1_val) >= $signed(rs2_val);
			default: br_taken = 1'b0;
		endcase
		case (dec.wb_sel)
			wb_imm: wb_data = dec.imm;
			wb_pc4: wb_data = pc_i + 32'd4;
			default: wb_data = alu_res;
		endcase
	end

	assign take = state_q == exec_run && instr_valid_i;
	assign instr_take_o = take;
	assign redirect_o = take && (dec.jump || (dec.branch && br_taken));
	assign target_o = pc_i + dec.imm;

	// load data takes the single write port in the ack cycle
	always_comb begin
		if (state_q == exec_mem_wait) begin
			rf_we = rsp_i.ack && !write_q;
			rf_waddr = rd_q;
			rf_wdata = rsp_i.rdata;
		end else begin
			rf_we = take && dec.reg_write;
			rf_waddr = dec.rd;
			rf_wdata = wb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < num_regs; i++) begin
				rf[i] <= '0;
			end
		end else if (rf_we && rf_waddr != '0) begin
			rf[rf_waddr] <= rf_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= exec_run;
		end else if (take && dec.mem_access) begin
			state_q <= exec_mem_wait;
		end else if (state_q == exec_mem_wait && rsp_i.ack) begin
			state_q <= exec_run;
		end
	end

	always_ff @(posedge clk) begin
		if (take && dec.mem_access) begin
			addr_q <= {alu_res[xlen-1:2], 2'b00};
			wdata_q <= rs2_val;
			write_q <= dec.mem_write;
			rd_q <= dec.rd;
		end
	end

	always_comb begin
		req_o.valid = state_q == exec_mem_wait;
		req_o.write = write_q;
		req_o.addr = addr_q;
		req_o.wdata = wdata_q;
	end

endmodule

/* logic/bus_arbiter.sv */
`timescale 1ns/1ns

module bus_arbiter (
	input logic clk,
	input logic rst_i,
	input rv_core_pkg::mem_req_t exec_req_i,
	input rv_core_pkg::mem_req_t fetch_req_i,
	output rv_core_pkg::mem_rsp_t exec_rsp_o,
	output rv_core_pkg::mem_rsp_t fetch_rsp_o,
	output rv_core_pkg::mem_req_t bus_req_o,
	input rv_core_pkg::mem_rsp_t bus_rsp_i
);
	import rv_core_pkg::*;

	logic busy_q;
	logic grant_exec_q;
	logic sel_exec;

	// data side wins when both ask in the same idle cycle
	assign sel_exec = busy_q ? grant_exec_q : exec_req_i.valid;
	assign bus_req_o = sel_exec ? exec_req_i : fetch_req_i;

	always_comb begin
		exec_rsp_o.ack = bus_rsp_i.ack && sel_exec;
		exec_rsp_o.rdata = sel_exec ? bus_rsp_i.rdata : '0;
		fetch_rsp_o.ack = bus_rsp_i.ack && !sel_exec;
		fetch_rsp_o.rdata = sel_exec ? '0 : bus_rsp_i.rdata;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy_q <= 1'b0;
			grant_exec_q <= 1'b0;
		end else if (!busy_q) begin
			if (bus_req_o.valid) begin
				busy_q <= 1'b1;
				grant_exec_q <= sel_exec;
			end
		end else if (bus_rsp_i.ack) begin
			busy_q <= 1'b0;
		end
	end

endmodule

/* logic/apb_master.sv */
`timescale 1ns/1ns

module apb_master (
	input logic clk,
	input logic rst_i,
	input rv_core_pkg::mem_req_t req_i,
	output rv_core_pkg::mem_rsp_t rsp_o,
	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output rv_core_pkg::word_t paddr_o,
	output rv_core_pkg::word_t pwdata_o,
	input rv_core_pkg::word_t prdata_i,
	input logic pready_i
);
	import rv_core_pkg::*;

	apb_state_e state_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= apb_idle;
		end else begin
			case (state_q)
				apb_idle: if (req_i.valid) state_q <= apb_setup;
				apb_setup: state_q <= apb_access;
				apb_access: if (pready_i) state_q <= apb_idle;
				default: state_q <= apb_idle;
			endcase
		end
	end

	// captured once, held through setup and access
	always_ff @(posedge clk) begin
		if (state_q == apb_idle && req_i.valid) begin
			paddr_o <= req_i.addr;
			pwdata_o <= req_i.wdata;
			pwrite_o <= req_i.write;
		end
	end

	assign psel_o = state_q != apb_idle;
	assign penable_o = state_q == apb_access;
	assign rsp_o.ack = state_q == apb_access && pready_i;
	assign rsp_o.rdata = prdata_i;

endmodule

/* logic/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top (
	input logic clk,
	input logic rst_i,
	output logic psel_o,
	output logic penable_o,
	output logic pwrite_o,
	output rv_core_pkg::word_t paddr_o,
	output rv_core_pkg::word_t pwdata_o,
	input rv_core_pkg::word_t prdata_i,
	input logic pready_i
);
	import rv_core_pkg::*;

	mem_req_t fetch_req;
	mem_req_t exec_req;
	mem_req_t bus_req;
	mem_rsp_t fetch_rsp;
	mem_rsp_t exec_rsp;
	mem_rsp_t bus_rsp;
	logic redirect;
	word_t target;
	logic instr_valid;
	logic instr_take;
	word_t instr;
	word_t instr_pc;

	fetch_unit u_fetch (
		.clk(clk),
		.rst_i(rst_i),
		.redirect_i(redirect),
		.target_i(target),
		.instr_take_i(instr_take),
		.req_o(fetch_req),
		.rsp_i(fetch_rsp),
		.instr_valid_o(instr_valid),
		.instr_o(instr),
		.pc_o(instr_pc)
	);

	exec_unit u_exec (
		.clk(clk),
		.rst_i(rst_i),
		.instr_valid_i(instr_valid),
		.instr_i(instr),
		.pc_i(instr_pc),
		.instr_take_o(instr_take),
		.redirect_o(redirect),
		.target_o(target),
		.req_o(exec_req),
		.rsp_i(exec_rsp)
	);

	bus_arbiter u_arbiter (
		.clk(clk),
		.rst_i(rst_i),
		.exec_req_i(exec_req),
		.fetch_req_i(fetch_req),
		.exec_rsp_o(exec_rsp),
		.fetch_rsp_o(fetch_rsp),
		.bus_req_o(bus_req),
		.bus_rsp_i(bus_rsp)
	);

	apb_master u_apb (
		.clk(clk),
		.rst_i(rst_i),
		.req_i(bus_req),
		.rsp_o(bus_rsp),
		.psel_o(psel_o),
		.penable_o(penable_o),
		.pwrite_o(pwrite_o),
		.paddr_o(paddr_o),
		.pwdata_o(pwdata_o),
		.prdata_i(prdata_i),
		.pready_i(pready_i)
	);

endmodule

/* dv/core_assert.sv */
`timescale 1ns/1ns

module core_assert (
	input logic clk,
	input logic rst_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input rv_core_pkg::word_t paddr_i,
	input rv_core_pkg::word_t pwdata_i,
	input logic pready_i
);
	// read back by the testbench at the end of the run
	int unsigned violations = 0;

	setup_then_access: assert property (@(posedge clk) disable iff (rst_i)
		psel_i && !penable_i |=> psel_i && penable_i)
		else begin
			$error("APB setup cycle not followed by an access cycle");
			violations++;
		end

	// access never starts without a setup cycle in front
	access_after_setup: assert property (@(posedge clk) disable iff (rst_i)
		$rose(penable_i) |-> $past(psel_i && !penable_i))
		else begin
			$error("APB penable rose without a preceding setup cycle");
			violations++;
		end

	stable_while_waiting: assert property (@(posedge clk) disable iff (rst_i)
		psel_i && !pready_i |=> $stable(paddr_i) && $stable(pwrite_i) && $stable(pwdata_i))
		else begin
			$error("APB address, direction or write data changed during a transfer");
			violations++;
		end

	word_aligned: assert property (@(posedge clk) disable iff (rst_i)
		psel_i |-> paddr_i[1:0] == 2'b00)
		else begin
			$error("APB address is not word aligned");
			violations++;
		end

endmodule

bind apb_master core_assert apb_checks (
	.clk(clk),
	.rst_i(rst_i),
	.psel_i(psel_o),
	.penable_i(penable_o),
	.pwrite_i(pwrite_o),
	.paddr_i(paddr_o),
	.pwdata_i(pwdata_o),
	.pready_i(pready_i)
);

/* dv/core_tb.sv */
`timescale 1ns/1ns

module core_tb;
	import rv_core_pkg::*;

	localparam int clk_period = 10;
	localparam int mem_words = 1024;
	localparam int max_tests = 16;
	localparam int max_stores = 64;
	localparam int drain_cycles = 100;
	localparam golden_path = "dv/core_golden.txt";

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	word_t paddr;
	word_t pwdata;
	word_t prdata = '0;
	logic pready = 1'b0;

	word_t mem [mem_words];
	string test_names [max_tests];
	int test_end [max_tests];
	int test_errs [max_tests];
	word_t exp_addr [max_stores];
	word_t exp_data [max_stores];
	int exp_test [max_stores];
	int num_tests = 0;
	int num_exp = 0;
	int prog_words = 0;
	int store_idx = 0;
	int errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int assert_fails = 0;
	int wait_left = 0;
	logic golden_loaded = 1'b0;
	logic [31:0] rnd_state = 32'd19269;

	rv_core_top DUT (
		.clk(clk),
		.rst_i(rst),
		.psel_o(psel),
		.penable_o(penable),
		.pwrite_o(pwrite),
		.paddr_o(paddr),
		.pwdata_o(pwdata),
		.prdata_i(prdata),
		.pready_i(pready)
	);

	initial begin
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t fill_word(input word_t addr);
		return addr ^ 32'h5ee0_0b1d;
	endfunction

	function automatic word_t mem_read(input word_t addr);
		if (addr < mem_words * 4) begin
			return mem[addr[11:2]];
		end else begin
			return fill_word(addr);
		end
	endfunction

	task automatic load_golden();
		int fd;
		int n;
		int last;
		string line;
		word_t a;
		word_t d;
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = fill_word(i * 4);
		end
		fd = $fopen(golden_path, "r");
		if (fd == 0) begin
			$display("cannot open golden file %s", golden_path);
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				case (line.getc(0))
					"P": begin
						n = $sscanf(line, "P %h %h", a, d);
						if (n != 2) begin
							$display("malformed program line in golden file: %s", line);
							errors++;
						end else if (a < mem_words * 4) begin
							mem[a[11:2]] = d;
						end
						prog_words++;
					end
					"T": begin
						last = line.len() - 1;
						while (last > 2 && line.getc(last) <= 8'h20) begin
							last--;
						end
						test_names[num_tests] = line.substr(2, last);
						test_end[num_tests] = -1;
						test_errs[num_tests] = 0;
						num_tests++;
					end
					"S": begin
						n = $sscanf(line, "S %h %h", a, d);
						if (n != 2 || num_tests == 0) begin
							$display("malformed store line in golden file: %s", line);
							errors++;
						end else begin
							exp_addr[num_exp] = a;
							exp_data[num_exp] = d;
							exp_test[num_exp] = num_tests - 1;
							test_end[num_tests - 1] = num_exp;
							num_exp++;
						end
					end
					default: begin
					end
				endcase
			end
			$fclose(fd);
			golden_loaded = 1'b1;
		end
	endtask

	task automatic compare_word(input int t, input string what, input word_t expected,
			input word_t actual);
		if (expected !== actual) begin
			$display("CHECK FAILED test %s, store %0d %s: expected %h, actual %h",
				test_names[t], store_idx, what, expected, actual);
			errors++;
			test_errs[t]++;
		end
	endtask

	task automatic report_test(input int t);
		if (test_errs[t] == 0) begin
			$display("test %s: pass", test_names[t]);
			tests_passed++;
		end else begin
			$display("test %s: FAIL with %0d mismatches", test_names[t], test_errs[t]);
			tests_failed++;
		end
	endtask

	task automatic record_store(input word_t addr, input word_t data);
		int t;
		if (addr < mem_words * 4) begin
			mem[addr[11:2]] = data;
		end
		if (store_idx >= num_exp) begin
			$display("unexpected store of %h to address %h after the last expected store",
				data, addr);
			errors++;
		end else begin
			t = exp_test[store_idx];
			compare_word(t, "address", exp_addr[store_idx], addr);
			compare_word(t, "data", exp_data[store_idx], data);
			if (store_idx == test_end[t]) begin
				report_test(t);
			end
			store_idx++;
		end
	endtask

	// APB memory slave with 0 to 3 wait states per access
	always @(posedge clk) begin
		if (rst) begin
			pready <= 1'b0;
			wait_left <= 0;
		end else if (psel && !penable) begin
			rnd_state = xorshift32(rnd_state);
			wait_left <= rnd_state[1:0];
			pready <= rnd_state[1:0] == 2'd0;
			prdata <= mem_read(paddr);
		end else if (psel && penable && !pready) begin
			wait_left <= wait_left - 1;
			pready <= wait_left == 1;
		end else if (psel && penable && pready) begin
			if (pwrite) begin
				record_store(paddr, pwdata);
			end
			pready <= 1'b0;
		end else begin
			pready <= 1'b0;
		end
	end

	initial begin
		rst = 1'b1;
		load_golden();
		if (golden_loaded) begin
			repeat (4) @(posedge clk);
			rst <= 1'b0;
			wait (store_idx >= num_exp);
			// window for stray stores from skipped code
			repeat (drain_cycles) @(posedge clk);
		end
		assert_fails = DUT.u_apb.apb_checks.violations;
		$display("tests passed %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_passed, tests_failed, errors, assert_fails);
		if (golden_loaded && errors == 0 && tests_failed == 0 && assert_fails == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		wait (golden_loaded);
		#(prog_words * 40 * clk_period);
		$display("watchdog expired, the core hung after %0d of %0d expected stores",
			store_idx, num_exp);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* dv/core_golden.txt */
# P <addr> <word>   program image, hex
# T <name>          starts a test, S <addr> <data> expected stores in order, hex
T alu
P 00000000 06400093
P 00000004 FF900113
P 00000008 002081B3
P 0000000C 40302023
P 00000010 401101B3
P 00000014 40302223
P 00000018 0F017193
P 0000001C 40302423
P 00000020 0020E1B3
P 00000024 40302623
P 00000028 FFF0C193
P 0000002C 40302823
P 00000030 001121B3
P 00000034 40302A23
P 00000038 00513193
P 0000003C 40302C23
P 00000040 001091B3
P 00000044 40302E23
P 00000048 001151B3
P 0000004C 42302023
P 00000050 40115193
P 00000054 42302223
S 00000400 0000005D
S 00000404 FFFFFF95
S 00000408 000000F0
S 0000040C FFFFFFFD
S 00000410 FFFFFF9B
S 00000414 00000001
S 00000418 00000000
S 0000041C 00000640
S 00000420 0FFFFFFF
S 00000424 FFFFFFFC
T lui_x0
P 00000058 12345237
P 0000005C 67820213
P 00000060 42402423
P 00000064 DEADC2B7
P 00000068 EEF28293
P 0000006C 42502623
P 00000070 00500013
P 00000074 42002823
S 00000428 12345678
S 0000042C DEADBEEF
S 00000430 00000000
T load_use
P 00000078 42502A23
P 0000007C 43402303
P 00000080 00130313
P 00000084 42602C23
S 00000434 DEADBEEF
S 00000438 DEADBEF0
# markers at 0x8c, 0x9c and 0xac are skipped and must never store
T branch_jal
P 00000088 00108463
P 0000008C 42102E23
P 00000090 00109463
P 00000094 44202023
P 00000098 00114463
P 0000009C 44102223
P 000000A0 00115463
P 000000A4 44102423
P 000000A8 008003EF
P 000000AC 44102623
P 000000B0 44702823
S 00000440 FFFFFFF9
S 00000448 00000064
S 00000450 000000AC
T wait_order
P 000000B4 44102A23
P 000000B8 40002403
P 000000BC 00640433
P 000000C0 44802C23
P 000000C4 45402483
P 000000C8 44902E23
P 000000CC 0000006F
S 00000454 00000064
S 00000458 DEADBF4D
S 0000045C 00000064

/* all.f */
logic/rv_core_pkg.sv
logic/fetch_unit.sv
logic/exec_unit.sv
logic/bus_arbiter.sv
logic/apb_master.sv
logic/rv_core_top.sv
dv/core_assert.sv
dv/core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - logic/rv_core_pkg.sv
  - logic/fetch_unit.sv
  - logic/exec_unit.sv
  - logic/bus_arbiter.sv
  - logic/apb_master.sv
  - logic/rv_core_top.sv
  - target: test
    files:
      - dv/core_assert.sv
      - dv/core_tb.sv
